/* rtl/csr_pkg.sv */
/*
 * CSR decode package
 * address view, pipeline payload types, CSR identifiers and the
 * exact-address attribute table used by the decode stage
 */

`default_nettype none

package csr_pkg;

   localparam int CSR_ADDR_W = 12;
   localparam int CSR_NUM    = 22;

   // bits 11:4 shared by the debug-mode-only CSRs
   localparam logic [7:0] DEBUG_RANGE = 8'h7B;

   // ******************************
   // address, raw word or RISC-V fields
   // ******************************
   typedef struct packed {
      logic [1:0] access;
      logic [1:0] priv;
      logic [7:0] index;
   } csr_addr_f_t;

   typedef union packed {
      logic [CSR_ADDR_W-1:0] raw;
      csr_addr_f_t           f;
   } csr_addr_u;

   typedef enum logic [4:0] {
      CSR_NONE = 5'd0,
      CSR_MSTATUS,
      CSR_MISA,
      CSR_MIE,
      CSR_MTVEC,
      CSR_MSCRATCH,
      CSR_MEPC,
      CSR_MCAUSE,
      CSR_MTVAL,
      CSR_MIP,
      CSR_MCYCLE,
      CSR_MCYCLEH,
      CSR_MINSTRET,
      CSR_MINSTRETH,
      CSR_MVENDORID,
      CSR_MARCHID,
      CSR_MIMPID,
      CSR_MHARTID,
      CSR_DCSR,
      CSR_DPC,
      CSR_MITCNT0,
      CSR_MITB0,
      CSR_MITCTL0
   } csr_id_e;

   typedef struct packed {
      logic [CSR_ADDR_W-1:0] addr;
      csr_id_e               id;
      logic                  presync;
      logic                  postsync;
   } csr_attr_t;

   // ******************************
   // kept CSRs
   // ******************************
   // counters wait for older instructions, state changers flush younger ones
   localparam csr_attr_t CSR_TABLE [CSR_NUM] = '{
      '{addr: 12'h300, id: CSR_MSTATUS,   presync: 1'b0, postsync: 1'b1},
      '{addr: 12'h301, id: CSR_MISA,      presync: 1'b0, postsync: 1'b0},
      '{addr: 12'h304, id: CSR_MIE,       presync: 1'b0, postsync: 1'b1},
      '{addr: 12'h305, id: CSR_MTVEC,     presync: 1'b0, postsync: 1'b1},
      '{addr: 12'h340, id: CSR_MSCRATCH,  presync: 1'b0, postsync: 1'b0},
      '{addr: 12'h341, id: CSR_MEPC,      presync: 1'b0, postsync: 1'b1},
      '{addr: 12'h342, id: CSR_MCAUSE,    presync: 1'b0, postsync: 1'b0},
      '{addr: 12'h343, id: CSR_MTVAL,     presync: 1'b0, postsync: 1'b0},
      '{addr: 12'h344, id: CSR_MIP,       presync: 1'b0, postsync: 1'b0},
      '{addr: 12'hB00, id: CSR_MCYCLE,    presync: 1'b1, postsync: 1'b0},
      '{addr: 12'hB80, id: CSR_MCYCLEH,   presync: 1'b1, postsync: 1'b0},
      '{addr: 12'hB02, id: CSR_MINSTRET,  presync: 1'b1, postsync: 1'b0},
      '{addr: 12'hB82, id: CSR_MINSTRETH, presync: 1'b1, postsync: 1'b0},
      '{addr: 12'hF11, id: CSR_MVENDORID, presync: 1'b0, postsync: 1'b0},
      '{addr: 12'hF12, id: CSR_MARCHID,   presync: 1'b0, postsync: 1'b0},
      '{addr: 12'hF13, id: CSR_MIMPID,    presync: 1'b0, postsync: 1'b0},
      '{addr: 12'hF14, id: CSR_MHARTID,   presync: 1'b0, postsync: 1'b0},
      '{addr: 12'h7B0, id: CSR_DCSR,      presync: 1'b0, postsync: 1'b1},
      '{addr: 12'h7B1, id: CSR_DPC,       presync: 1'b0, postsync: 1'b1},
      '{addr: 12'h7D2, id: CSR_MITCNT0,   presync: 1'b0, postsync: 1'b0},
      '{addr: 12'h7D3, id: CSR_MITB0,     presync: 1'b0, postsync: 1'b0},
      '{addr: 12'h7D4, id: CSR_MITCTL0,   presync: 1'b0, postsync: 1'b1}
   };

   // ******************************
   // pipeline payloads
   // ******************************
   typedef struct packed {
      csr_addr_u addr;
      logic      wen;
      logic      dbg_halted;
   } csr_req_t;

   typedef struct packed {
      csr_id_e id;
      logic    known;
      logic    read_only;
      logic    debug_only;
      logic    presync;
      logic    postsync;
      logic    wen;
      logic    dbg_halted;
   } csr_dec_t;

   typedef struct packed {
      csr_id_e id;
      logic    legal;
      logic    presync;
      logic    postsync;
   } csr_resp_t;

endpackage

`default_nettype wire

/* rtl/csr_addr_decode.sv */
/*
 * CSR address decode, pipeline stage 1
 * looks up the identifier and sync attributes of a CSR address,
 * derives the read-only and debug-only rules from its fields
 */

`timescale 1ns/1ps
`default_nettype none

module csr_addr_decode
   import csr_pkg::*;
(
   input  logic     clk,
   input  logic     reset,

   input  logic     req_valid,
   input  csr_req_t req,
   output logic     req_ready,

   output logic     dec_valid,
   output csr_dec_t dec,
   input  logic     dec_ready
);

   csr_id_e  hit_id;
   logic     hit_known;
   logic     hit_presync;
   logic     hit_postsync;
   logic     read_only;
   logic     debug_only;
   csr_dec_t dec_next;

   // ******************************
   // exact address lookup
   // ******************************
   always_comb begin
      hit_id       = CSR_NONE;
      hit_known    = 1'b0;
      hit_presync  = 1'b0;
      hit_postsync = 1'b0;
      for (int i = 0; i < CSR_NUM; i++) begin
         if (CSR_TABLE[i].addr == req.addr.raw) begin
            hit_id       = CSR_TABLE[i].id;
            hit_known    = 1'b1;
            hit_presync  = CSR_TABLE[i].presync;
            hit_postsync = CSR_TABLE[i].postsync;
         end
      end
   end

   // ******************************
   // rules from the address fields
   // ******************************
   // access 2'b11 is the read-only quadrant of the CSR space
   assign read_only = (req.addr.f.access == 2'b11);

   // 0x7B0-0x7BF only reachable in debug mode
   assign debug_only = ({req.addr.f.access, req.addr.f.priv, req.addr.f.index[7:4]}
                        == DEBUG_RANGE);

   always_comb begin
      dec_next.id         = hit_id;
      dec_next.known      = hit_known;
      dec_next.read_only  = read_only;
      dec_next.debug_only = debug_only;
      dec_next.presync    = hit_presync;
      dec_next.postsync   = hit_postsync;
      dec_next.wen        = req.wen;
      dec_next.dbg_halted = req.dbg_halted;
   end

   // ******************************
   // output slot
   // ******************************
   // take a new item when empty or when the current one leaves this cycle
   assign req_ready = ~dec_valid | dec_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         dec_valid <= 1'b0;
      end else if (req_ready) begin
         dec_valid <= req_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         dec <= dec_next;
      end
   end

endmodule

`default_nettype wire

/* rtl/csr_access_check.sv */
/*
 * CSR access check, pipeline stage 2
 * applies write, debug-mode and timer configuration rules to a decoded
 * CSR access and registers the legal and sync response
 */

`timescale 1ns/1ps
`default_nettype none

module csr_access_check
   import csr_pkg::*;
#(
   parameter bit TIMER_LEGAL_EN = 1'b1
) (
   input  logic      clk,
   input  logic      reset,

   input  logic      dec_valid,
   input  csr_dec_t  dec,
   output logic      dec_ready,

   output logic      resp_valid,
   output csr_resp_t resp,
   input  logic      resp_ready
);

   logic      timer_csr;
   logic      debug_block;
   logic      ro_write;
   logic      timer_block;
   logic      legal;
   csr_resp_t resp_next;

   // ******************************
   // legality rules
   // ******************************
   assign timer_csr = (dec.id == CSR_MITCNT0) |
                      (dec.id == CSR_MITB0)   |
                      (dec.id == CSR_MITCTL0);

   // debug CSRs while the core runs
   assign debug_block = dec.debug_only & ~dec.dbg_halted;

   // identity CSRs and the rest of the read-only quadrant
   assign ro_write = dec.wen & dec.read_only;

   // internal timer not built in
   assign timer_block = timer_csr & ~TIMER_LEGAL_EN;

   assign legal = dec.known & ~debug_block & ~ro_write & ~timer_block;

   always_comb begin
      resp_next.id       = dec.id;
      resp_next.legal    = legal;
      // counter writes need no wait, only reads must see older retires
      resp_next.presync  = dec.presync & ~dec.wen;
      resp_next.postsync = dec.postsync;
   end

   // ******************************
   // output slot
   // ******************************
   assign dec_ready = ~resp_valid | resp_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         resp_valid <= 1'b0;
      end else if (dec_ready) begin
         resp_valid <= dec_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (dec_valid && dec_ready) begin
         resp <= resp_next;
      end
   end

endmodule

`default_nettype wire

/* rtl/csr_decode_top.sv */
/*
 * CSR decoder top
 * two-stage valid/ready pipeline, address decode then access check
 */

`timescale 1ns/1ps
`default_nettype none

module csr_decode_top
   import csr_pkg::*;
#(
   parameter bit TIMER_LEGAL_EN = 1'b1
) (
   input  logic      clk,
   input  logic      reset,

   input  logic      req_valid,
   input  csr_req_t  req,
   output logic      req_ready,

   output logic      resp_valid,
   output csr_resp_t resp,
   input  logic      resp_ready
);

   // stage 1 to stage 2 link
   logic     dec_valid;
   csr_dec_t dec;
   logic     dec_ready;

   // ******************************
   // stage 1
   // ******************************
   csr_addr_decode i_csr_addr_decode (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .dec_valid (dec_valid),
      .dec       (dec),
      .dec_ready (dec_ready)
   );

   // ******************************
   // stage 2
   // ******************************
   csr_access_check #(
      .TIMER_LEGAL_EN (TIMER_LEGAL_EN)
   ) i_csr_access_check (
      .clk        (clk),
      .reset      (reset),
      .dec_valid  (dec_valid),
      .dec        (dec),
      .dec_ready  (dec_ready),
      .resp_valid (resp_valid),
      .resp       (resp),
      .resp_ready (resp_ready)
   );

endmodule

`default_nettype wire

/* tb/csr_decode_checker.sv */
/*
 * CSR decoder response checker
 * assertions on the output handshake of the decoder top
 */

`timescale 1ns/1ps
`default_nettype none

module csr_decode_checker
   import csr_pkg::*;
(
   input logic      clk,
   input logic      reset,
   input logic      resp_valid,
   input csr_resp_t resp,
   input logic      resp_ready
);

   // ******************************
   // output handshake
   // ******************************
   assert property (@(posedge clk) reset |=> !resp_valid)
      else $error("resp_valid high in the cycle after reset");

   assert property (@(posedge clk) disable iff (reset)
                    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
      else $error("stalled response changed or dropped");

   assert property (@(posedge clk) disable iff (reset)
                    resp_valid && resp.legal |-> resp.id != CSR_NONE)
      else $error("legal response for an unknown CSR");

endmodule

bind csr_decode_top csr_decode_checker i_csr_decode_checker (
   .clk        (clk),
   .reset      (reset),
   .resp_valid (resp_valid),
   .resp       (resp),
   .resp_ready (resp_ready)
);

`default_nettype wire

/* tb/csr_decode_vectors.svh */
/*
 * CSR decoder test table
 * one row per request, expected response written for TIMER_LEGAL_EN = 0
 */

`ifndef CSR_DECODE_VECTORS_SVH
`define CSR_DECODE_VECTORS_SVH

// columns: name, addr, wen, dbg_halted, expected id, legal, presync, postsync
task automatic load_table();
   add_row("mstatus_rd",   12'h300, 1'b0, 1'b0, CSR_MSTATUS,   1'b1, 1'b0, 1'b1);
   add_row("misa_rd",      12'h301, 1'b0, 1'b0, CSR_MISA,      1'b1, 1'b0, 1'b0);
   add_row("mie_rd",       12'h304, 1'b0, 1'b0, CSR_MIE,       1'b1, 1'b0, 1'b1);
   add_row("mtvec_rd",     12'h305, 1'b0, 1'b0, CSR_MTVEC,     1'b1, 1'b0, 1'b1);
   add_row("mscratch_rd",  12'h340, 1'b0, 1'b0, CSR_MSCRATCH,  1'b1, 1'b0, 1'b0);
   add_row("mepc_rd",      12'h341, 1'b0, 1'b0, CSR_MEPC,      1'b1, 1'b0, 1'b1);
   add_row("mcause_rd",    12'h342, 1'b0, 1'b0, CSR_MCAUSE,    1'b1, 1'b0, 1'b0);
   add_row("mtval_rd",     12'h343, 1'b0, 1'b0, CSR_MTVAL,     1'b1, 1'b0, 1'b0);
   add_row("mip_rd",       12'h344, 1'b0, 1'b0, CSR_MIP,       1'b1, 1'b0, 1'b0);
   add_row("mcycle_rd",    12'hB00, 1'b0, 1'b0, CSR_MCYCLE,    1'b1, 1'b1, 1'b0);
   add_row("mcycleh_rd",   12'hB80, 1'b0, 1'b0, CSR_MCYCLEH,   1'b1, 1'b1, 1'b0);
   add_row("minstret_rd",  12'hB02, 1'b0, 1'b0, CSR_MINSTRET,  1'b1, 1'b1, 1'b0);
   add_row("minstreth_rd", 12'hB82, 1'b0, 1'b0, CSR_MINSTRETH, 1'b1, 1'b1, 1'b0);
   add_row("mvendorid_rd", 12'hF11, 1'b0, 1'b0, CSR_MVENDORID, 1'b1, 1'b0, 1'b0);
   add_row("marchid_rd",   12'hF12, 1'b0, 1'b0, CSR_MARCHID,   1'b1, 1'b0, 1'b0);
   add_row("mimpid_rd",    12'hF13, 1'b0, 1'b0, CSR_MIMPID,    1'b1, 1'b0, 1'b0);
   add_row("mhartid_rd",   12'hF14, 1'b0, 1'b0, CSR_MHARTID,   1'b1, 1'b0, 1'b0);
   add_row("mvendorid_wr", 12'hF11, 1'b1, 1'b0, CSR_MVENDORID, 1'b0, 1'b0, 1'b0);
   add_row("mhartid_wr",   12'hF14, 1'b1, 1'b1, CSR_MHARTID,   1'b0, 1'b0, 1'b0);
   // debug CSRs, running then halted
   add_row("dcsr_rd_run",  12'h7B0, 1'b0, 1'b0, CSR_DCSR,      1'b0, 1'b0, 1'b1);
   add_row("dcsr_rd_halt", 12'h7B0, 1'b0, 1'b1, CSR_DCSR,      1'b1, 1'b0, 1'b1);
   add_row("dpc_rd_halt",  12'h7B1, 1'b0, 1'b1, CSR_DPC,       1'b1, 1'b0, 1'b1);
   add_row("dpc_wr_run",   12'h7B1, 1'b1, 1'b0, CSR_DPC,       1'b0, 1'b0, 1'b1);
   add_row("dpc_wr_halt",  12'h7B1, 1'b1, 1'b1, CSR_DPC,       1'b1, 1'b0, 1'b1);
   // timer not built in
   add_row("mitcnt0_rd",   12'h7D2, 1'b0, 1'b0, CSR_MITCNT0,   1'b0, 1'b0, 1'b0);
   add_row("mitb0_rd",     12'h7D3, 1'b0, 1'b0, CSR_MITB0,     1'b0, 1'b0, 1'b0);
   add_row("mitb0_wr",     12'h7D3, 1'b1, 1'b0, CSR_MITB0,     1'b0, 1'b0, 1'b0);
   add_row("mitctl0_rd",   12'h7D4, 1'b0, 1'b0, CSR_MITCTL0,   1'b0, 1'b0, 1'b1);
   add_row("mitctl0_wr",   12'h7D4, 1'b1, 1'b1, CSR_MITCTL0,   1'b0, 1'b0, 1'b1);
   // counter writes skip presync
   add_row("mcycle_wr",    12'hB00, 1'b1, 1'b0, CSR_MCYCLE,    1'b1, 1'b0, 1'b0);
   add_row("minstreth_wr", 12'hB82, 1'b1, 1'b0, CSR_MINSTRETH, 1'b1, 1'b0, 1'b0);
   add_row("mstatus_wr",   12'h300, 1'b1, 1'b0, CSR_MSTATUS,   1'b1, 1'b0, 1'b1);
   add_row("unknown_rd",   12'h123, 1'b0, 1'b0, CSR_NONE,      1'b0, 1'b0, 1'b0);
   add_row("unknown_ro",   12'hFFF, 1'b0, 1'b1, CSR_NONE,      1'b0, 1'b0, 1'b0);
   add_row("unknown_dbg",  12'h7BF, 1'b0, 1'b1, CSR_NONE,      1'b0, 1'b0, 1'b0);
endtask

`endif

/* tb/csr_decode_tb.sv */
/*
 * CSR decoder testbench
 * drives the request table through the pipeline under random
 * back-pressure and checks every response in order
 */

`timescale 1ns/1ps
`default_nettype none

module csr_decode_tb
   import csr_pkg::*;
();

   localparam int unsigned RAND_SEED = 32'ha53192b4;
   // about 35 rows at a few cycles each under stalls, with wide margin
   localparam int TIMEOUT_CYCLES = 1000;
   // responses taken with resp_ready held high, latency checked on the first ones
   localparam int HIGH_ROWS      = 12;
   localparam int LATENCY_ROWS   = 10;
   localparam int LATENCY        = 2;

   typedef struct packed {
      logic [CSR_ADDR_W-1:0] addr;
      logic                  wen;
      logic                  dbg_halted;
      csr_id_e               id;
      logic                  legal;
      logic                  presync;
      logic                  postsync;
   } row_t;

   logic      clk;
   logic      reset;
   logic      req_valid;
   csr_req_t  req;
   logic      req_ready;
   logic      resp_valid;
   csr_resp_t resp;
   logic      resp_ready;

   row_t  rows[$];
   string names[$];
   int    accept_edge[$];
   int    resp_count;
   int    sent;
   int    cycle;

   csr_decode_top #(
      .TIMER_LEGAL_EN (1'b0)
   ) i_csr_decode_top (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp       (resp),
      .resp_ready (resp_ready)
   );

   // ******************************
   // clock and cycle count
   // ******************************
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      cycle = 0;
      forever begin
         @(posedge clk);
         cycle = cycle + 1;
         if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d responses received",
                     cycle, resp_count, rows.size());
            abort_run();
         end
      end
   end

   // ******************************
   // helpers
   // ******************************
   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string test, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Fail %s %s: expected %0h, actual %0h", test, field, expected, actual);
         abort_run();
      end
   endtask

   task automatic add_row(input string name, input logic [CSR_ADDR_W-1:0] addr,
                          input logic wen, input logic dbg_halted, input csr_id_e id,
                          input logic legal, input logic presync, input logic postsync);
      row_t r;
      r.addr       = addr;
      r.wen        = wen;
      r.dbg_halted = dbg_halted;
      r.id         = id;
      r.legal      = legal;
      r.presync    = presync;
      r.postsync   = postsync;
      rows.push_back(r);
      names.push_back(name);
   endtask

   // one request per row, held until the pipeline takes it
   task automatic drive_rows();
      for (int i = 0; i < rows.size(); i++) begin
         req_valid      = 1'b1;
         req.addr.raw   = rows[i].addr;
         req.wen        = rows[i].wen;
         req.dbg_halted = rows[i].dbg_halted;
         @(negedge clk);
         while (!req_ready) @(negedge clk);
         accept_edge.push_back(cycle + 1);
         @(posedge clk);
         #1;
      end
      req_valid = 1'b0;
   endtask

   task automatic check_response();
      row_t  exp;
      string name;
      if (accept_edge.size() <= resp_count) begin
         $display("Response %0d arrived with no accepted request left", resp_count);
         abort_run();
      end else begin
         exp  = rows[resp_count];
         name = names[resp_count];
         check_value(name, "id", exp.id, resp.id);
         check_value(name, "legal", exp.legal, resp.legal);
         check_value(name, "presync", exp.presync, resp.presync);
         check_value(name, "postsync", exp.postsync, resp.postsync);
         if (resp_count < LATENCY_ROWS) begin
            check_value(name, "latency", LATENCY, cycle + 1 - accept_edge[resp_count]);
         end
         resp_count = resp_count + 1;
      end
   endtask

   // ******************************
   // back-pressure and monitor
   // ******************************
   initial begin
      int unsigned seed_out;
      seed_out = $urandom(RAND_SEED);
      forever begin
         @(posedge clk);
         #1;
         if (resp_count < HIGH_ROWS) begin
            resp_ready = 1'b1;
         end else begin
            resp_ready = ($urandom % 3) != 0;
         end
      end
   end

   // req_ready drops only with both slots full and the output stalled
   initial begin
      logic expect_ready;
      forever begin
         @(negedge clk);
         expect_ready = !((sent - resp_count) == 2 && !resp_ready);
         check_value("handshake", "req_ready", expect_ready, req_ready);
         if (req_valid && req_ready) begin
            sent = sent + 1;
         end
         if (resp_valid && resp_ready) begin
            check_response();
         end
      end
   end

   // ******************************
   // main sequence
   // ******************************
   initial begin
      reset      = 1'b1;
      req_valid  = 1'b0;
      req        = '0;
      resp_ready = 1'b0;
      resp_count = 0;
      sent       = 0;
      load_table();
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      drive_rows();
      wait (resp_count == rows.size());
      // let any extra response show up
      repeat (4) @(posedge clk);
      $display(">>> PASS");
      $finish;
   end

   `include "csr_decode_vectors.svh"

endmodule

`default_nettype wire

/* build.f */
+incdir+tb
rtl/csr_pkg.sv
rtl/csr_addr_decode.sv
rtl/csr_access_check.sv
rtl/csr_decode_top.sv
tb/csr_decode_checker.sv
tb/csr_decode_tb.sv
